// File: mips_pipe.f
+incdir+testbench
source/mips_pipe_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/register_file.sv
source/execute_stage.sv
source/mips_pipe.sv
testbench/mips_pipe_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the mips_pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module mips_pipe_tb -f mips_pipe.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vmips_pipe_tb > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

echo "simulation passed"
exit 0

// File: source/decode_stage.sv
`default_nettype none

module decode_stage
    import mips_pipe_pkg::*;
(
    input  wire             clk,
    input  wire             reset,
    input  wire  word_t     i_instr,
    input  wire  word_t     i_pc,
    input  wire             i_valid,
    input  wire             i_flush,
    // register file read data, same cycle
    input  wire  word_t     i_rs_data,
    input  wire  word_t     i_rt_data,
    output reg_addr_t       o_rs_addr,
    output reg_addr_t       o_rt_addr,
    // decode-to-execute register
    output op_e             o_op,
    output alu_sel_e        o_alu_sel,
    output word_t           o_src_a,
    output word_t           o_src_b,
    output word_t           o_imm,
    output logic            o_use_imm,
    output reg_addr_t       o_rs,
    output reg_addr_t       o_rt,
    output reg_addr_t       o_dest,
    output logic            o_reg_write,
    output word_t           o_pc,
    output logic            o_valid
);

    logic [OPC_W-1:0]   opc;
    logic [OPC_W-1:0]   funct;
    logic [IMM_W-1:0]   imm16;
    logic [INDEX_W-1:0] index;
    reg_addr_t          rd;
    op_e                op;
    alu_sel_e           alu_sel;
    logic               use_imm;
    logic               dest_is_rt;
    logic               zero_ext;
    logic               writes;
    reg_addr_t          dest;
    word_t              imm;

    // field split
    assign opc       = i_instr[OPC_LSB +: OPC_W];
    assign funct     = i_instr[FUNCT_LSB +: OPC_W];
    assign imm16     = i_instr[0 +: IMM_W];
    assign index     = i_instr[0 +: INDEX_W];
    assign rd        = i_instr[RD_LSB +: REG_ADDR_W];
    assign o_rs_addr = i_instr[RS_LSB +: REG_ADDR_W];
    assign o_rt_addr = i_instr[RT_LSB +: REG_ADDR_W];

    // opcode and funct onto op and alu function
    always_comb begin
        op         = OP_NOP;
        alu_sel    = ALU_ADD;
        use_imm    = 1'b0;
        dest_is_rt = 1'b0;
        zero_ext   = 1'b0;
        case (opc)
            OPC_SPECIAL: begin
                case (funct)
                    FUNCT_ADDU: begin op = OP_ADDU; alu_sel = ALU_ADD; end
                    FUNCT_SUBU: begin op = OP_SUBU; alu_sel = ALU_SUB; end
                    FUNCT_AND:  begin op = OP_AND;  alu_sel = ALU_AND; end
                    FUNCT_OR:   begin op = OP_OR;   alu_sel = ALU_OR;  end
                    FUNCT_XOR:  begin op = OP_XOR;  alu_sel = ALU_XOR; end
                    FUNCT_SLT:  begin op = OP_SLT;  alu_sel = ALU_SLT; end
                    FUNCT_SLL:  begin op = OP_SLL;  alu_sel = ALU_SLL; end
                    default:    op = OP_NOP;
                endcase
            end
            OPC_ADDIU: begin
                op = OP_ADDIU;
                use_imm = 1'b1;
                dest_is_rt = 1'b1;
            end
            OPC_ORI: begin
                op = OP_ORI;
                alu_sel = ALU_OR;
                use_imm = 1'b1;
                dest_is_rt = 1'b1;
                zero_ext = 1'b1;
            end
            OPC_LUI: begin
                op = OP_LUI;
                alu_sel = ALU_LUI;
                use_imm = 1'b1;
                dest_is_rt = 1'b1;
            end
            OPC_BEQ: begin op = OP_BEQ; alu_sel = ALU_SUB; end
            OPC_BNE: begin op = OP_BNE; alu_sel = ALU_SUB; end
            OPC_J:   op = OP_J;
            default: op = OP_NOP;
        endcase
    end

    // branches, jump and nop leave the register file alone
    assign writes = (op != OP_NOP) && (op != OP_BEQ) && (op != OP_BNE) && (op != OP_J);
    assign dest   = dest_is_rt ? o_rt_addr : rd;

    // J carries its 26-bit index in the immediate slot
    always_comb begin
        if (op == OP_J) begin
            imm = {{(DATA_W-INDEX_W){1'b0}}, index};
        end else if (zero_ext) begin
            imm = {{(DATA_W-IMM_W){1'b0}}, imm16};
        end else begin
            imm = {{(DATA_W-IMM_W){imm16[IMM_W-1]}}, imm16};
        end
    end

    // control part, cleared by reset or flush
    always_ff @(posedge clk) begin
        if (reset || i_flush) begin
            o_valid     <= 1'b0;
            o_reg_write <= 1'b0;
            o_op        <= OP_NOP;
        end else begin
            o_valid <= i_valid;
            // r0 destination never writes
            o_reg_write <= i_valid && writes && (dest != '0);
            o_op        <= op;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        o_alu_sel <= alu_sel;
        o_src_a   <= i_rs_data;
        o_src_b   <= i_rt_data;
        o_imm     <= imm;
        o_use_imm <= use_imm;
        o_rs      <= o_rs_addr;
        o_rt      <= o_rt_addr;
        o_dest    <= dest;
        o_pc      <= i_pc;
    end

endmodule

`default_nettype wire

// File: source/execute_stage.sv
`default_nettype none

module execute_stage
    import mips_pipe_pkg::*;
(
    input  wire             clk,
    input  wire             reset,
    // from the decode-to-execute register
    input  wire  op_e       i_op,
    input  wire  alu_sel_e  i_alu_sel,
    input  wire  word_t     i_src_a,
    input  wire  word_t     i_src_b,
    input  wire  word_t     i_imm,
    input  wire             i_use_imm,
    input  wire  reg_addr_t i_rs,
    input  wire  reg_addr_t i_rt,
    input  wire  reg_addr_t i_dest,
    input  wire             i_reg_write,
    input  wire  word_t     i_pc,
    input  wire             i_valid,
    // taken branch or jump
    output logic            o_redirect,
    output word_t           o_target,
    // writeback register
    output logic            o_wb_valid,
    output reg_addr_t       o_wb_addr,
    output word_t           o_wb_data
);

    word_t                fwd_a;
    word_t                fwd_b;
    word_t                opnd_b;
    word_t                result;
    word_t                pc_plus4;
    word_t                branch_target;
    word_t                jump_target;
    logic [SHAMT_W-1:0]   shamt;
    logic                 operands_eq;
    logic                 taken;

    // bypass from the writeback register, one instruction ahead
    // two ahead is covered by write-through in the register file
    always_comb begin
        if (o_wb_valid && (o_wb_addr != '0) && (o_wb_addr == i_rs)) begin
            fwd_a = o_wb_data;
        end else begin
            fwd_a = i_src_a;
        end
        if (o_wb_valid && (o_wb_addr != '0) && (o_wb_addr == i_rt)) begin
            fwd_b = o_wb_data;
        end else begin
            fwd_b = i_src_b;
        end
    end

    assign opnd_b = i_use_imm ? i_imm : fwd_b;
    // shamt rides in the sign-extended immediate
    assign shamt  = i_imm[SHAMT_LSB +: SHAMT_W];

    // alu, adds wrap silently
    always_comb begin
        case (i_alu_sel)
            ALU_ADD: result = fwd_a + opnd_b;
            ALU_SUB: result = fwd_a - opnd_b;
            ALU_AND: result = fwd_a & opnd_b;
            ALU_OR:  result = fwd_a | opnd_b;
            ALU_XOR: result = fwd_a ^ opnd_b;
            ALU_SLT: result = word_t'($signed(fwd_a) < $signed(opnd_b));
            ALU_SLL: result = fwd_b << shamt;
            ALU_LUI: result = {opnd_b[IMM_W-1:0], {(DATA_W-IMM_W){1'b0}}};
            default: result = '0;
        endcase
    end

    // branch resolution
    assign operands_eq   = (fwd_a == fwd_b);
    assign pc_plus4      = i_pc + word_t'(4);
    assign branch_target = pc_plus4 + {i_imm[DATA_W-3:0], 2'b00};
    assign jump_target   = {pc_plus4[DATA_W-1:DATA_W-4], i_imm[INDEX_W-1:0], 2'b00};

    always_comb begin
        case (i_op)
            OP_J:    taken = 1'b1;
            OP_BEQ:  taken = operands_eq;
            OP_BNE:  taken = ~operands_eq;
            default: taken = 1'b0;
        endcase
    end

    assign o_redirect = i_valid && taken;
    assign o_target   = (i_op == OP_J) ? jump_target : branch_target;

    // writeback register
    always_ff @(posedge clk) begin
        if (reset) begin
            o_wb_valid <= 1'b0;
        end else begin
            o_wb_valid <= i_valid && i_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        o_wb_addr <= i_dest;
        o_wb_data <= result;
    end

endmodule

`default_nettype wire

// File: source/fetch_stage.sv
`default_nettype none

module fetch_stage
    import mips_pipe_pkg::*;
#(
    parameter word_t RESET_PC = 32'hbfc0_0000
) (
    input  wire         clk,
    input  wire         reset,
    // branch or jump taken in execute
    input  wire         i_redirect,
    input  wire  word_t i_target,
    output word_t       o_imem_addr,
    // word arriving from memory this cycle
    output word_t       o_pending_pc,
    output logic        o_pending_valid
);

    word_t pc;
    word_t pc_next;

    // sequential fetch unless execute redirects
    always_comb begin
        if (i_redirect) begin
            pc_next = i_target;
        end else begin
            pc_next = pc + word_t'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc              <= RESET_PC;
            o_pending_valid <= 1'b0;
        end else begin
            pc <= pc_next;
            // word requested this cycle is stale after a redirect
            o_pending_valid <= ~i_redirect;
        end
    end

    // address of the word in flight, one cycle behind pc
    always_ff @(posedge clk) begin
        o_pending_pc <= pc;
    end

    // memory sees the pc directly
    assign o_imem_addr = pc;

endmodule

`default_nettype wire

// File: source/mips_pipe.sv
`default_nettype none

module mips_pipe
    import mips_pipe_pkg::*;
#(
    parameter word_t RESET_PC = 32'hbfc0_0000
) (
    input  wire         clk,
    input  wire         reset,
    // instruction memory, one-cycle read latency
    output word_t       o_imem_addr,
    input  wire  word_t i_imem_data,
    // writeback trace
    output logic        o_wb_valid,
    output reg_addr_t   o_wb_addr,
    output word_t       o_wb_data
);

    // fetch to decode
    logic      redirect;
    word_t     target;
    word_t     pending_pc;
    logic      pending_valid;

    // decode to register file
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;

    // decode-to-execute register
    op_e       de_op;
    alu_sel_e  de_alu_sel;
    word_t     de_src_a;
    word_t     de_src_b;
    word_t     de_imm;
    logic      de_use_imm;
    reg_addr_t de_rs;
    reg_addr_t de_rt;
    reg_addr_t de_dest;
    logic      de_reg_write;
    word_t     de_pc;
    logic      de_valid;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) fetch_stage_i (
        .clk             (clk),
        .reset           (reset),
        .i_redirect      (redirect),
        .i_target        (target),
        .o_imem_addr     (o_imem_addr),
        .o_pending_pc    (pending_pc),
        .o_pending_valid (pending_valid)
    );

    // redirect also drops the instruction in decode
    decode_stage decode_stage_i (
        .clk         (clk),
        .reset       (reset),
        .i_instr     (i_imem_data),
        .i_pc        (pending_pc),
        .i_valid     (pending_valid),
        .i_flush     (redirect),
        .i_rs_data   (rs_data),
        .i_rt_data   (rt_data),
        .o_rs_addr   (rs_addr),
        .o_rt_addr   (rt_addr),
        .o_op        (de_op),
        .o_alu_sel   (de_alu_sel),
        .o_src_a     (de_src_a),
        .o_src_b     (de_src_b),
        .o_imm       (de_imm),
        .o_use_imm   (de_use_imm),
        .o_rs        (de_rs),
        .o_rt        (de_rt),
        .o_dest      (de_dest),
        .o_reg_write (de_reg_write),
        .o_pc        (de_pc),
        .o_valid     (de_valid)
    );

    // write port fed straight from the writeback register
    register_file register_file_i (
        .clk       (clk),
        .reset     (reset),
        .i_rs_addr (rs_addr),
        .i_rt_addr (rt_addr),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data),
        .i_we      (o_wb_valid),
        .i_waddr   (o_wb_addr),
        .i_wdata   (o_wb_data)
    );

    execute_stage execute_stage_i (
        .clk         (clk),
        .reset       (reset),
        .i_op        (de_op),
        .i_alu_sel   (de_alu_sel),
        .i_src_a     (de_src_a),
        .i_src_b     (de_src_b),
        .i_imm       (de_imm),
        .i_use_imm   (de_use_imm),
        .i_rs        (de_rs),
        .i_rt        (de_rt),
        .i_dest      (de_dest),
        .i_reg_write (de_reg_write),
        .i_pc        (de_pc),
        .i_valid     (de_valid),
        .o_redirect  (redirect),
        .o_target    (target),
        .o_wb_valid  (o_wb_valid),
        .o_wb_addr   (o_wb_addr),
        .o_wb_data   (o_wb_data)
    );

endmodule

`default_nettype wire

// File: source/mips_pipe_pkg.sv
`default_nettype none

package mips_pipe_pkg;

    // machine widths
    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int REG_COUNT  = 32;

    typedef logic [DATA_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // instruction field positions
    localparam int OPC_LSB   = 26;
    localparam int RS_LSB    = 21;
    localparam int RT_LSB    = 16;
    localparam int RD_LSB    = 11;
    localparam int SHAMT_LSB = 6;
    localparam int FUNCT_LSB = 0;
    // opcode and funct share one width
    localparam int OPC_W     = 6;
    localparam int SHAMT_W   = 5;
    localparam int IMM_W     = 16;
    localparam int INDEX_W   = 26;

    // major opcodes
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_J       = 6'h02;
    localparam logic [5:0] OPC_BEQ     = 6'h04;
    localparam logic [5:0] OPC_BNE     = 6'h05;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_LUI     = 6'h0f;

    // function codes under OPC_SPECIAL
    localparam logic [5:0] FUNCT_SLL  = 6'h00;
    localparam logic [5:0] FUNCT_ADDU = 6'h21;
    localparam logic [5:0] FUNCT_SUBU = 6'h23;
    localparam logic [5:0] FUNCT_AND  = 6'h24;
    localparam logic [5:0] FUNCT_OR   = 6'h25;
    localparam logic [5:0] FUNCT_XOR  = 6'h26;
    localparam logic [5:0] FUNCT_SLT  = 6'h2a;

    typedef enum logic [3:0] {
        OP_NOP, OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_SLT,
        OP_SLL, OP_ADDIU, OP_ORI, OP_LUI, OP_BEQ, OP_BNE, OP_J
    } op_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_LUI
    } alu_sel_e;

endpackage

`default_nettype wire

// File: source/register_file.sv
`default_nettype none

module register_file
    import mips_pipe_pkg::*;
(
    input  wire             clk,
    input  wire             reset,
    // two read ports
    input  wire  reg_addr_t i_rs_addr,
    input  wire  reg_addr_t i_rt_addr,
    output word_t           o_rs_data,
    output word_t           o_rt_data,
    // one write port from writeback
    input  wire             i_we,
    input  wire  reg_addr_t i_waddr,
    input  wire  word_t     i_wdata
);

    word_t regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_waddr != '0)) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // r0 reads zero, same-cycle write passes through
    always_comb begin
        if (i_rs_addr == '0) begin
            o_rs_data = '0;
        end else if (i_we && (i_waddr == i_rs_addr)) begin
            o_rs_data = i_wdata;
        end else begin
            o_rs_data = regs[i_rs_addr];
        end
        if (i_rt_addr == '0) begin
            o_rt_data = '0;
        end else if (i_we && (i_waddr == i_rt_addr)) begin
            o_rt_data = i_wdata;
        end else begin
            o_rt_data = regs[i_rt_addr];
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

    // program size in words, register writes it makes
    localparam int PROG_LEN = 29;
    localparam int EXP_LEN  = 17;

    word_t     rom [PROG_LEN];
    reg_addr_t exp_addr [EXP_LEN];
    word_t     exp_data [EXP_LEN];
    string     exp_name [EXP_LEN];

    // one row of the expected trace
    task automatic expect_write(input logic [4:0] slot_idx, input string name,
                                input reg_addr_t addr, input word_t data);
        exp_name[slot_idx] = name;
        exp_addr[slot_idx] = addr;
        exp_data[slot_idx] = data;
    endtask

    task automatic load_program();
        // constants, ori zero-extends, addiu sign-extends
        rom[0]  = itype_word(OPC_LUI,   5'd1,  5'd0,  16'h1234);
        rom[1]  = itype_word(OPC_ORI,   5'd1,  5'd1,  16'h5678);
        rom[2]  = itype_word(OPC_ADDIU, 5'd2,  5'd0,  16'hfffd);
        rom[3]  = itype_word(OPC_ORI,   5'd3,  5'd0,  16'h8001);
        // r-type chain, sources one and two instructions back
        rom[4]  = rtype_word(FUNCT_ADDU, 5'd4,  5'd1, 5'd2, 5'd0);
        rom[5]  = rtype_word(FUNCT_SUBU, 5'd5,  5'd4, 5'd3, 5'd0);
        rom[6]  = rtype_word(FUNCT_AND,  5'd6,  5'd1, 5'd5, 5'd0);
        rom[7]  = rtype_word(FUNCT_OR,   5'd7,  5'd3, 5'd1, 5'd0);
        rom[8]  = rtype_word(FUNCT_XOR,  5'd8,  5'd7, 5'd6, 5'd0);
        rom[9]  = rtype_word(FUNCT_SLT,  5'd9,  5'd2, 5'd3, 5'd0);
        rom[10] = rtype_word(FUNCT_SLT,  5'd10, 5'd3, 5'd2, 5'd0);
        rom[11] = rtype_word(FUNCT_SLL,  5'd11, 5'd0, 5'd3, 5'd4);
        // write to r0, must not show on the trace
        rom[12] = rtype_word(FUNCT_ADDU, 5'd0,  5'd1, 5'd2, 5'd0);
        rom[13] = itype_word(OPC_ADDIU, 5'd12, 5'd0,  16'h0005);
        rom[14] = itype_word(OPC_ADDIU, 5'd13, 5'd0,  16'h0005);
        // taken beq to 18, skips 16 and 17
        rom[15] = itype_word(OPC_BEQ,   5'd13, 5'd12, 16'h0002);
        rom[16] = itype_word(OPC_ADDIU, 5'd14, 5'd0,  16'h0111);
        rom[17] = itype_word(OPC_ADDIU, 5'd15, 5'd0,  16'h0222);
        // taken bne to 21, skips 19 and 20
        rom[18] = itype_word(OPC_BNE,   5'd9,  5'd12, 16'h0002);
        rom[19] = itype_word(OPC_ADDIU, 5'd14, 5'd0,  16'h0333);
        rom[20] = itype_word(OPC_ADDIU, 5'd15, 5'd0,  16'h0444);
        // both fall through, a wrong take would skip the write at 23
        rom[21] = itype_word(OPC_BEQ,   5'd9,  5'd12, 16'h0005);
        rom[22] = itype_word(OPC_BNE,   5'd13, 5'd12, 16'h0005);
        rom[23] = itype_word(OPC_ADDIU, 5'd14, 5'd12, 16'hffff);
        // jump to 27
        rom[24] = jump_word(RESET_PC + 32'd108);
        rom[25] = itype_word(OPC_ADDIU, 5'd15, 5'd0,  16'h0555);
        rom[26] = itype_word(OPC_ADDIU, 5'd15, 5'd0,  16'h0666);
        rom[27] = itype_word(OPC_ADDIU, 5'd15, 5'd14, 16'h7fff);
        rom[28] = rtype_word(FUNCT_ADDU, 5'd16, 5'd15, 5'd15, 5'd0);

        // trace in program order
        expect_write(5'd0,  "lui r1",         5'd1,  32'h1234_0000);
        expect_write(5'd1,  "ori r1 fwd",     5'd1,  32'h1234_5678);
        expect_write(5'd2,  "addiu negative", 5'd2,  32'hffff_fffd);
        expect_write(5'd3,  "ori zero ext",   5'd3,  32'h0000_8001);
        expect_write(5'd4,  "addu wrap",      5'd4,  32'h1234_5675);
        expect_write(5'd5,  "subu",           5'd5,  32'h1233_d674);
        expect_write(5'd6,  "and",            5'd6,  32'h1230_5670);
        expect_write(5'd7,  "or",             5'd7,  32'h1234_d679);
        expect_write(5'd8,  "xor",            5'd8,  32'h0004_8009);
        expect_write(5'd9,  "slt negative",   5'd9,  32'h0000_0001);
        expect_write(5'd10, "slt false",      5'd10, 32'h0000_0000);
        expect_write(5'd11, "sll by 4",       5'd11, 32'h0008_0010);
        expect_write(5'd12, "addiu r12",      5'd12, 32'h0000_0005);
        expect_write(5'd13, "addiu r13",      5'd13, 32'h0000_0005);
        expect_write(5'd14, "after branches", 5'd14, 32'h0000_0004);
        expect_write(5'd15, "jump target",    5'd15, 32'h0000_8003);
        expect_write(5'd16, "addu self",      5'd16, 32'h0001_0006);
    endtask

`endif

// File: testbench/mips_pipe_tb.sv
`default_nettype none

module mips_pipe_tb
    import mips_pipe_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam word_t RESET_PC     = 32'hbfc0_0000;
    localparam int    RESET_CYCLES = 16;
    localparam int    TAIL_CYCLES  = 12;

    // r-type word from its fields
    function automatic word_t rtype_word(input logic [5:0] funct, input reg_addr_t rd,
                                         input reg_addr_t rs, input reg_addr_t rt,
                                         input logic [4:0] shamt);
        return {OPC_SPECIAL, rs, rt, rd, shamt, funct};
    endfunction

    // i-type word with rt as destination or second compare operand
    function automatic word_t itype_word(input logic [5:0] opc, input reg_addr_t rt,
                                         input reg_addr_t rs, input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    // j word for an absolute target in the same 256 MB region
    function automatic word_t jump_word(input word_t target);
        return {OPC_J, target[27:2]};
    endfunction

    `include "tb_program.svh"

    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 4 * PROG_LEN + 50;

    logic       clk;
    logic       reset;
    word_t      imem_addr;
    word_t      imem_data;
    logic       wb_valid;
    reg_addr_t  wb_addr;
    word_t      wb_data;
    int         seen;
    int         after_reset;
    int         cycles;
    logic [4:0] slot;

    // rom lookup with a self-jump past the end of the table
    function automatic word_t fetch_word(input word_t addr);
        word_t offset;
        offset = (addr - RESET_PC) >> 2;
        if (offset < word_t'(PROG_LEN)) begin
            return rom[offset[4:0]];
        end else begin
            return jump_word(addr);
        end
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    mips_pipe #(
        .RESET_PC (RESET_PC)
    ) mips_pipe_i (
        .clk         (clk),
        .reset       (reset),
        .o_imem_addr (imem_addr),
        .i_imem_data (imem_data),
        .o_wb_valid  (wb_valid),
        .o_wb_addr   (wb_addr),
        .o_wb_data   (wb_data)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // instruction memory returns data one cycle after the address
    initial begin
        imem_data = '0;
        forever begin
            @(posedge clk);
            imem_data <= fetch_word(imem_addr);
        end
    end

    // run limit from program length
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, only %0d of %0d expected writes seen",
                 cycles, seen, EXP_LEN);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped on timeout");
    end

    initial begin
        reset       = 1'b1;
        seen        = 0;
        after_reset = 1;
        slot        = '0;
        load_program();
        repeat (RESET_CYCLES) begin
            @(posedge clk);
        end
        reset <= 1'b0;

        // first falling edge after reset release
        @(negedge clk);
        check_value("boot address", RESET_PC, imem_addr);

        // first write lands three cycles after the boot fetch
        while (seen < EXP_LEN) begin
            if (wb_valid) begin
                slot = seen[4:0];
                if (seen == 0) begin
                    check_value("first write cycle", 32'd4, word_t'(after_reset));
                end
                check_value({exp_name[slot], " addr"}, word_t'(exp_addr[slot]),
                            word_t'(wb_addr));
                check_value({exp_name[slot], " data"}, exp_data[slot], wb_data);
                seen++;
            end
            @(negedge clk);
            after_reset++;
        end

        // core spins on the self-jump with no further writes
        repeat (TAIL_CYCLES) begin
            @(negedge clk);
            check_value("no write after end", 32'd0, word_t'(wb_valid));
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
